// ==== compile.f ====
+incdir+include
source/timer_pkg.sv
source/timer_prescaler.sv
source/timer_counter.sv
source/timer_regs.sv
source/timer_top.sv
verif/timer_tb.sv

// ==== source/timer_counter.sv ====
// Wrap-around tick counter
`timescale 1ns/1ps

module timer_counter (
    input  logic                          i_clk,
    input  logic                          i_arst,
    input  logic                          i_enable,
    input  logic                          i_clr,
    input  logic                          i_tick,
    input  logic [timer_pkg::COUNT_W-1:0] i_max,
    output logic [timer_pkg::COUNT_W-1:0] o_count,
    output logic                          o_match_pulse
);

    logic advance;
    logic at_max;

    // A tick arriving after enable drops is lost
    assign advance = i_enable && i_tick;

    // Max lowered below the count also forces a wrap
    assign at_max = (o_count >= i_max);

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            o_count <= '0;
        end else if (i_clr) begin
            o_count <= '0;
        end else if (advance) begin
            if (at_max) begin
                o_count <= '0;
            end else begin
                o_count <= o_count + 1'b1;
            end
        end
    end

    // Single-cycle pulse on the wrap edge
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            o_match_pulse <= 1'b0;
        end else if (i_clr) begin
            o_match_pulse <= 1'b0;
        end else begin
            o_match_pulse <= advance && at_max;
        end
    end

endmodule

// ==== source/timer_pkg.sv ====
// Timer register map
package timer_pkg;

    // Bus widths
    localparam int ADDR_W     = 5;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;

    // Core widths
    localparam int PRESCALE_W = 8;
    localparam int COUNT_W    = 16;

    // Register byte offsets
    localparam logic [ADDR_W-1:0] REG_CTRL     = 5'h00;
    localparam logic [ADDR_W-1:0] REG_PRESCALE = 5'h04;
    localparam logic [ADDR_W-1:0] REG_MAX      = 5'h08;
    localparam logic [ADDR_W-1:0] REG_COUNT    = 5'h0C;
    localparam logic [ADDR_W-1:0] REG_STATUS   = 5'h10;

    // CTRL fields with a self-clearing CLR pulse
    localparam int CTRL_EN     = 0;
    localparam int CTRL_IRQ_EN = 1;
    localparam int CTRL_CLR    = 2;

    // STATUS fields
    localparam int STATUS_MATCH = 0;

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Shared by the write and read channel machines
    typedef enum logic [1:0] {
        BUS_IDLE = 2'd0,
        BUS_RESP = 2'd1,
        BUS_DATA = 2'd2
    } bus_state_t;

endpackage

// ==== source/timer_prescaler.sv ====
// Timer clock prescaler
`timescale 1ns/1ps

module timer_prescaler (
    input  logic                             i_clk,
    input  logic                             i_arst,
    input  logic                             i_enable,
    input  logic                             i_clr,
    input  logic [timer_pkg::PRESCALE_W-1:0] i_prescale,
    output logic                             o_tick
);

    logic [timer_pkg::PRESCALE_W-1:0] pre_cnt;

    // One tick every prescale+1 enabled cycles
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            pre_cnt <= '0;
            o_tick  <= 1'b0;
        end else if (i_clr) begin
            // Phase restarts from zero
            pre_cnt <= '0;
            o_tick  <= 1'b0;
        end else if (!i_enable) begin
            pre_cnt <= '0;
            o_tick  <= 1'b0;
        end else if (pre_cnt >= i_prescale) begin
            pre_cnt <= '0;
            o_tick  <= 1'b1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            o_tick  <= 1'b0;
        end
    end

endmodule

// ==== source/timer_regs.sv ====
// AXI4-Lite timer registers
`timescale 1ns/1ps

module timer_regs (
    input  logic                             i_clk,
    input  logic                             i_arst,

    // Write address and data
    input  logic                             i_awvalid,
    input  logic [timer_pkg::ADDR_W-1:0]     i_awaddr,
    output logic                             o_awready,
    input  logic                             i_wvalid,
    input  logic [timer_pkg::DATA_W-1:0]     i_wdata,
    input  logic [timer_pkg::STRB_W-1:0]     i_wstrb,
    output logic                             o_wready,

    // Write response
    output logic                             o_bvalid,
    output logic [1:0]                       o_bresp,
    input  logic                             i_bready,

    // Read address and data
    input  logic                             i_arvalid,
    input  logic [timer_pkg::ADDR_W-1:0]     i_araddr,
    output logic                             o_arready,
    output logic                             o_rvalid,
    output logic [timer_pkg::DATA_W-1:0]     o_rdata,
    output logic [1:0]                       o_rresp,
    input  logic                             i_rready,

    // Timer core
    input  logic [timer_pkg::COUNT_W-1:0]    i_count,
    input  logic                             i_match_pulse,
    output logic                             o_enable,
    output logic                             o_clr,
    output logic [timer_pkg::PRESCALE_W-1:0] o_prescale,
    output logic [timer_pkg::COUNT_W-1:0]    o_max,
    output logic                             o_irq
);

    timer_pkg::bus_state_t wr_state;
    timer_pkg::bus_state_t rd_state;

    logic wr_accept;
    logic wr_ctrl;
    logic wr_prescale;
    logic wr_max;
    logic wr_count;
    logic wr_status;
    logic wr_mapped;

    logic rd_accept;
    logic rd_err;
    logic [timer_pkg::DATA_W-1:0] rd_mux;

    logic ctrl_irq_en;
    logic status_match;
    logic match_w1c;

    // Word decode ignoring the low two address bits
    function automatic logic hit(input logic [timer_pkg::ADDR_W-1:0] addr,
                                 input logic [timer_pkg::ADDR_W-1:0] offset);
        return addr[timer_pkg::ADDR_W-1:2] == offset[timer_pkg::ADDR_W-1:2];
    endfunction

    assign wr_ctrl     = hit(i_awaddr, timer_pkg::REG_CTRL);
    assign wr_prescale = hit(i_awaddr, timer_pkg::REG_PRESCALE);
    assign wr_max      = hit(i_awaddr, timer_pkg::REG_MAX);
    assign wr_count    = hit(i_awaddr, timer_pkg::REG_COUNT);
    assign wr_status   = hit(i_awaddr, timer_pkg::REG_STATUS);
    assign wr_mapped   = wr_ctrl | wr_prescale | wr_max | wr_count | wr_status;

    // AW and W are taken together and only with no response pending
    assign wr_accept = (wr_state == timer_pkg::BUS_IDLE) && i_awvalid && i_wvalid;
    assign o_awready = wr_accept;
    assign o_wready  = wr_accept;
    assign o_bvalid  = (wr_state == timer_pkg::BUS_RESP);

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            wr_state <= timer_pkg::BUS_IDLE;
            o_bresp  <= timer_pkg::RESP_OKAY;
        end else begin
            case (wr_state)
                timer_pkg::BUS_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= timer_pkg::BUS_RESP;
                        o_bresp  <= wr_mapped ? timer_pkg::RESP_OKAY : timer_pkg::RESP_SLVERR;
                    end
                end
                timer_pkg::BUS_RESP: begin
                    if (i_bready) begin
                        wr_state <= timer_pkg::BUS_IDLE;
                    end
                end
                default: wr_state <= timer_pkg::BUS_IDLE;
            endcase
        end
    end

    // Register file with byte strobes
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            o_enable    <= 1'b0;
            ctrl_irq_en <= 1'b0;
            o_clr       <= 1'b0;
            o_prescale  <= '0;
            o_max       <= '0;
        end else begin
            o_clr <= 1'b0;
            if (wr_accept && wr_ctrl && i_wstrb[0]) begin
                o_enable    <= i_wdata[timer_pkg::CTRL_EN];
                ctrl_irq_en <= i_wdata[timer_pkg::CTRL_IRQ_EN];
                o_clr       <= i_wdata[timer_pkg::CTRL_CLR];
            end
            if (wr_accept && wr_prescale && i_wstrb[0]) begin
                o_prescale <= i_wdata[7:0];
            end
            if (wr_accept && wr_max && i_wstrb[0]) begin
                o_max[7:0] <= i_wdata[7:0];
            end
            if (wr_accept && wr_max && i_wstrb[1]) begin
                o_max[15:8] <= i_wdata[15:8];
            end
        end
    end

    assign match_w1c = wr_accept && wr_status && i_wstrb[0] && i_wdata[timer_pkg::STATUS_MATCH];

    // Sticky flag where a new match beats a same-cycle clear
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            status_match <= 1'b0;
            o_irq        <= 1'b0;
        end else begin
            if (i_match_pulse) begin
                status_match <= 1'b1;
            end else if (match_w1c) begin
                status_match <= 1'b0;
            end
            o_irq <= status_match && ctrl_irq_en;
        end
    end

    // Read mux with zero-extended fields
    always_comb begin
        rd_mux = '0;
        rd_err = 1'b0;
        if (hit(i_araddr, timer_pkg::REG_CTRL)) begin
            rd_mux[timer_pkg::CTRL_EN]     = o_enable;
            rd_mux[timer_pkg::CTRL_IRQ_EN] = ctrl_irq_en;
        end else if (hit(i_araddr, timer_pkg::REG_PRESCALE)) begin
            rd_mux[timer_pkg::PRESCALE_W-1:0] = o_prescale;
        end else if (hit(i_araddr, timer_pkg::REG_MAX)) begin
            rd_mux[timer_pkg::COUNT_W-1:0] = o_max;
        end else if (hit(i_araddr, timer_pkg::REG_COUNT)) begin
            rd_mux[timer_pkg::COUNT_W-1:0] = i_count;
        end else if (hit(i_araddr, timer_pkg::REG_STATUS)) begin
            rd_mux[timer_pkg::STATUS_MATCH] = status_match;
        end else begin
            rd_err = 1'b1;
        end
    end

    assign rd_accept = o_arready && i_arvalid;
    assign o_rvalid  = (rd_state == timer_pkg::BUS_DATA);

    // Data is captured on the AR handshake and held until taken
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            rd_state  <= timer_pkg::BUS_IDLE;
            o_arready <= 1'b0;
            o_rdata   <= '0;
            o_rresp   <= timer_pkg::RESP_OKAY;
        end else begin
            case (rd_state)
                timer_pkg::BUS_IDLE: begin
                    o_arready <= 1'b1;
                    if (rd_accept) begin
                        rd_state  <= timer_pkg::BUS_DATA;
                        o_arready <= 1'b0;
                        o_rdata   <= rd_mux;
                        o_rresp   <= rd_err ? timer_pkg::RESP_SLVERR : timer_pkg::RESP_OKAY;
                    end
                end
                timer_pkg::BUS_DATA: begin
                    if (i_rready) begin
                        rd_state  <= timer_pkg::BUS_IDLE;
                        o_arready <= 1'b1;
                    end
                end
                default: begin
                    rd_state  <= timer_pkg::BUS_IDLE;
                    o_arready <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== source/timer_top.sv ====
// Timer peripheral top
`timescale 1ns/1ps

module timer_top (
    input  logic                         i_clk,
    input  logic                         i_arst,
    input  logic                         i_awvalid,
    input  logic [timer_pkg::ADDR_W-1:0] i_awaddr,
    output logic                         o_awready,
    input  logic                         i_wvalid,
    input  logic [timer_pkg::DATA_W-1:0] i_wdata,
    input  logic [timer_pkg::STRB_W-1:0] i_wstrb,
    output logic                         o_wready,
    output logic                         o_bvalid,
    output logic [1:0]                   o_bresp,
    input  logic                         i_bready,
    input  logic                         i_arvalid,
    input  logic [timer_pkg::ADDR_W-1:0] i_araddr,
    output logic                         o_arready,
    output logic                         o_rvalid,
    output logic [timer_pkg::DATA_W-1:0] o_rdata,
    output logic [1:0]                   o_rresp,
    input  logic                         i_rready,
    output logic                         o_irq
);

    logic                             enable;
    logic                             clr;
    logic                             tick;
    logic                             match_pulse;
    logic [timer_pkg::PRESCALE_W-1:0] prescale;
    logic [timer_pkg::COUNT_W-1:0]    max_val;
    logic [timer_pkg::COUNT_W-1:0]    count;

    timer_regs timer_regs_i (
        .i_clk         (i_clk),
        .i_arst        (i_arst),
        .i_awvalid     (i_awvalid),
        .i_awaddr      (i_awaddr),
        .o_awready     (o_awready),
        .i_wvalid      (i_wvalid),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .o_wready      (o_wready),
        .o_bvalid      (o_bvalid),
        .o_bresp       (o_bresp),
        .i_bready      (i_bready),
        .i_arvalid     (i_arvalid),
        .i_araddr      (i_araddr),
        .o_arready     (o_arready),
        .o_rvalid      (o_rvalid),
        .o_rdata       (o_rdata),
        .o_rresp       (o_rresp),
        .i_rready      (i_rready),
        .i_count       (count),
        .i_match_pulse (match_pulse),
        .o_enable      (enable),
        .o_clr         (clr),
        .o_prescale    (prescale),
        .o_max         (max_val),
        .o_irq         (o_irq)
    );

    timer_prescaler timer_prescaler_i (
        .i_clk      (i_clk),
        .i_arst     (i_arst),
        .i_enable   (enable),
        .i_clr      (clr),
        .i_prescale (prescale),
        .o_tick     (tick)
    );

    timer_counter timer_counter_i (
        .i_clk         (i_clk),
        .i_arst        (i_arst),
        .i_enable      (enable),
        .i_clr         (clr),
        .i_tick        (tick),
        .i_max         (max_val),
        .o_count       (count),
        .o_match_pulse (match_pulse)
    );

endmodule

// ==== include/timer_model.svh ====
// Timer reference model
`ifndef TIMER_MODEL_SVH
`define TIMER_MODEL_SVH

// Galois LFSR state and mirrored registers
logic [31:0] m_lfsr;
logic [31:0] m_ctrl;
logic [31:0] m_prescale;
logic [31:0] m_max;

// One LFSR step per bit taken
function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
        bits   = {bits[30:0], m_lfsr[0]};
        m_lfsr = (m_lfsr >> 1) ^ (m_lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return bits;
endfunction

function automatic logic [31:0] merge_strb(input logic [31:0] old_val,
                                           input logic [31:0] data,
                                           input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_val;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
    end
    return merged;
endfunction

// Called at the write handshake before the DUT enters BUS_RESP
function automatic void model_write(input logic [4:0] addr, input logic [31:0] data,
                                    input logic [3:0] strb);
    case (addr[4:2])
        timer_pkg::REG_CTRL[4:2]:     m_ctrl = merge_strb(m_ctrl, data, strb) & 32'h3;
        timer_pkg::REG_PRESCALE[4:2]: m_prescale = merge_strb(m_prescale, data, strb) & 32'hFF;
        timer_pkg::REG_MAX[4:2]:      m_max = merge_strb(m_max, data, strb) & 32'hFFFF;
        default: ;
    endcase
endfunction

// Expected value of a writable register or zero
function automatic logic [31:0] model_read(input logic [4:0] addr);
    case (addr[4:2])
        timer_pkg::REG_CTRL[4:2]:     return m_ctrl;
        timer_pkg::REG_PRESCALE[4:2]: return m_prescale;
        timer_pkg::REG_MAX[4:2]:      return m_max;
        default:                      return 32'h0;
    endcase
endfunction

function automatic logic [1:0] model_resp(input logic [4:0] addr);
    return (addr[4:2] <= timer_pkg::REG_STATUS[4:2]) ? timer_pkg::RESP_OKAY
                                                     : timer_pkg::RESP_SLVERR;
endfunction

// Count after e enabled edges from a zero prescaler phase
function automatic logic [31:0] expected_count(input int e, input int p, input int m);
    if (e < 1) return 32'h0;
    return ((e - 1) / (p + 1)) % (m + 1);
endfunction

`endif

// ==== verif/timer_tb.sv ====
// Timer peripheral testbench
`timescale 1ns/1ps

module timer_tb;

    localparam int CLK_PERIOD = 100;
    localparam int TXN_CYC    = 10;
    localparam int RUN_MAX    = 150;
    // Twice the worst-case cycles of all tests
    localparam int BUDGET = 2 * (8 + 7 * TXN_CYC + 80 * TXN_CYC
                          + 10 * (7 * TXN_CYC + RUN_MAX) + 4 * (8 * TXN_CYC + 60)
                          + 5 * TXN_CYC + 3 * (7 * TXN_CYC + 2 * RUN_MAX));
    localparam logic [31:0] EN_BIT    = 32'h1 << timer_pkg::CTRL_EN;
    localparam logic [31:0] IRQ_BIT   = 32'h1 << timer_pkg::CTRL_IRQ_EN;
    localparam logic [31:0] CLR_BIT   = 32'h1 << timer_pkg::CTRL_CLR;
    localparam logic [31:0] MATCH_BIT = 32'h1 << timer_pkg::STATUS_MATCH;

    logic i_clk = 1'b0;
    logic i_arst;
    logic i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
    logic i_arvalid, o_arready, o_rvalid, i_rready, o_irq;
    logic [timer_pkg::ADDR_W-1:0] i_awaddr, i_araddr;
    logic [31:0] i_wdata, o_rdata;
    logic [3:0]  i_wstrb;
    logic [1:0]  o_bresp, o_rresp;

    logic [31:0] rdata;
    logic [1:0]  rresp;
    time t0, t1, t2;
    int p, m, e, len;
    int err_cnt = 0;
    int test_base = 0;
    int test_cnt = 0;
    int fail_tests = 0;

    `include "timer_model.svh"

    timer_top timer_top_i (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge i_clk);
        #1;
    endtask

    // Returns the time of the AW/W handshake edge
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output time t_hs);
        logic seen;
        int delay;
        delay = lfsr_take(2);
        {i_awvalid, i_wvalid, i_awaddr, i_wdata, i_wstrb} = {2'b11, addr, data, strb};
        do begin
            @(negedge i_clk);
            seen = o_awready && o_wready;
            @(posedge i_clk);
        end while (!seen);
        t_hs = $time;
        model_write(addr, data, strb);
        #1;
        {i_awvalid, i_wvalid} = 2'b00;
        repeat (delay) @(posedge i_clk);
        #1;
        i_bready = 1'b1;
        do begin
            @(negedge i_clk);
            seen = o_bvalid;
            if (seen) check_val("o_bresp", o_bresp, model_resp(addr));
            @(posedge i_clk);
        end while (!seen);
        #1;
        i_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        logic seen;
        int delay;
        delay = lfsr_take(2);
        i_arvalid = 1'b1;
        i_araddr  = addr;
        do begin
            @(negedge i_clk);
            seen = o_arready;
            @(posedge i_clk);
        end while (!seen);
        #1;
        i_arvalid = 1'b0;
        repeat (delay) @(posedge i_clk);
        #1;
        i_rready = 1'b1;
        do begin
            @(negedge i_clk);
            seen = o_rvalid;
            data = o_rdata;
            resp = o_rresp;
            @(posedge i_clk);
        end while (!seen);
        #1;
        i_rready = 1'b0;
    endtask

    task automatic expect_irq(input logic exp);
        @(negedge i_clk);
        check_val("o_irq", o_irq, exp);
        @(posedge i_clk);
        #1;
    endtask

    // Loads prescale and max, then clears count and phase with the timer stopped
    task automatic setup_timer(input int pre, input int max);
        time t_unused;
        axi_write(timer_pkg::REG_PRESCALE, pre, 4'hF, t_unused);
        axi_write(timer_pkg::REG_MAX, max, 4'hF, t_unused);
        axi_write(timer_pkg::REG_CTRL, CLR_BIT, 4'hF, t_unused);
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == test_base) begin
            $display("%s: PASS", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, err_cnt - test_base);
            fail_tests++;
        end
        test_base = err_cnt;
    endtask

    initial begin
        #(BUDGET * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        {i_arst, i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready} = 6'b100000;
        {i_awaddr, i_araddr, i_wdata, i_wstrb} = '0;
        {m_ctrl, m_prescale, m_max} = '0;
        m_lfsr = 32'h491c96c6;
        repeat (8) @(posedge i_clk);
        #1;
        i_arst = 1'b0;

        for (int i = 0; i < 7; i++) begin
            axi_read(5'(i * 4), rdata, rresp);
            check_val("o_rdata", rdata, 32'h0);
            check_val("o_rresp", rresp, model_resp(5'(i * 4)));
        end
        expect_irq(1'b0);
        finish_test("reset_values");

        for (int i = 0; i < 40; i++) begin
            case (lfsr_take(2))
                0: i_araddr = timer_pkg::REG_CTRL;
                1: i_araddr = timer_pkg::REG_PRESCALE;
                default: i_araddr = timer_pkg::REG_MAX;
            endcase
            axi_write(i_araddr, lfsr_take(32), lfsr_take(4), t0);
            axi_read(i_araddr, rdata, rresp);
            check_val("o_rdata", rdata, model_read(i_araddr));
            check_val("o_rresp", rresp, timer_pkg::RESP_OKAY);
        end
        // Random CTRL values may have left the timer running
        axi_write(timer_pkg::REG_CTRL, 32'h0, 4'hF, t0);
        axi_write(timer_pkg::REG_STATUS, MATCH_BIT, 4'hF, t0);
        finish_test("register_access");

        for (int r = 0; r < 10; r++) begin
            p = lfsr_take(4);
            m = 32'h8000 | lfsr_take(15);
            setup_timer(p, m);
            axi_write(timer_pkg::REG_CTRL, EN_BIT, 4'hF, t1);
            idle_cycles(20 + lfsr_take(7));
            axi_write(timer_pkg::REG_CTRL, 32'h0, 4'hF, t2);
            e = (t2 - t1) / CLK_PERIOD;
            axi_read(timer_pkg::REG_COUNT, rdata, rresp);
            check_val("count", rdata, expected_count(e, p, m));
            idle_cycles(5);
            axi_read(timer_pkg::REG_COUNT, rdata, rresp);
            check_val("count_hold", rdata, expected_count(e, p, m));
        end
        finish_test("count_rate");

        for (int r = 0; r < 4; r++) begin
            p = lfsr_take(2);
            m = 1 + lfsr_take(3);
            len = (m + 1) * (p + 1) + lfsr_take(4);
            axi_write(timer_pkg::REG_STATUS, MATCH_BIT, 4'hF, t0);
            setup_timer(p, m);
            axi_write(timer_pkg::REG_CTRL, EN_BIT, 4'hF, t1);
            idle_cycles(len);
            axi_write(timer_pkg::REG_CTRL, 32'h0, 4'hF, t2);
            e = (t2 - t1) / CLK_PERIOD;
            axi_read(timer_pkg::REG_COUNT, rdata, rresp);
            check_val("count", rdata, expected_count(e, p, m));
            axi_read(timer_pkg::REG_STATUS, rdata, rresp);
            check_val("status", rdata, MATCH_BIT);
        end
        finish_test("wrap_match");

        axi_write(timer_pkg::REG_CTRL, IRQ_BIT, 4'hF, t0);
        idle_cycles(2);
        expect_irq(1'b1);
        axi_write(timer_pkg::REG_STATUS, 32'h0, 4'hF, t0);
        axi_read(timer_pkg::REG_STATUS, rdata, rresp);
        check_val("status", rdata, MATCH_BIT);
        expect_irq(1'b1);
        axi_write(timer_pkg::REG_STATUS, MATCH_BIT, 4'hF, t1);
        while ($time < t1 + 2 * CLK_PERIOD) @(posedge i_clk);
        expect_irq(1'b0);
        axi_read(timer_pkg::REG_STATUS, rdata, rresp);
        check_val("status", rdata, 32'h0);
        finish_test("interrupt");

        for (int r = 0; r < 3; r++) begin
            p = lfsr_take(3);
            m = 32'h8000 | lfsr_take(15);
            setup_timer(p, m);
            axi_write(timer_pkg::REG_CTRL, EN_BIT, 4'hF, t0);
            idle_cycles(20 + lfsr_take(6));
            axi_write(timer_pkg::REG_CTRL, EN_BIT | CLR_BIT, 4'hF, t1);
            idle_cycles(20 + lfsr_take(6));
            axi_write(timer_pkg::REG_CTRL, 32'h0, 4'hF, t2);
            // Clear lands one edge after the CTRL handshake
            e = (t2 - t1) / CLK_PERIOD - 1;
            axi_read(timer_pkg::REG_COUNT, rdata, rresp);
            check_val("count", rdata, expected_count(e, p, m));
        end
        finish_test("clear");

        $display("%0d tests run, %0d failed, %0d check errors", test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
